/* verilog/csr_consts.svh */
// Shared constants for the machine-mode CSR file
// CSR addresses, select codes, mstatus fields, funct3 codes, privilege codes
// Include wherever these names are used

`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define XLEN 32

// ==============================
// CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14
`define CSR_FFLAGS    12'h001
`define CSR_FRM       12'h002
`define CSR_FCSR      12'h003

// ==============================
// Register select codes
`define SEL_NONE      5'd0   // No such CSR
`define SEL_MSTATUS   5'd1
`define SEL_MISA      5'd2
`define SEL_MTVEC     5'd3
`define SEL_MSCRATCH  5'd4
`define SEL_MEPC      5'd5
`define SEL_MCAUSE    5'd6
`define SEL_MTVAL     5'd7
`define SEL_MVENDORID 5'd8
`define SEL_MARCHID   5'd9
`define SEL_MIMPID    5'd10
`define SEL_MHARTID   5'd11
`define SEL_FFLAGS    5'd12
`define SEL_FRM       5'd13
`define SEL_FCSR      5'd14

// mstatus fields kept
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_MPP_LSB  11
`define MSTATUS_MPP_MSB  12

// funct3 of the CSR instructions
`define CSR_RW  3'b001
`define CSR_RS  3'b010
`define CSR_RC  3'b011
`define CSR_RWI 3'b101
`define CSR_RSI 3'b110
`define CSR_RCI 3'b111

`define PRIV_U 2'b00
`define PRIV_M 2'b11

`define MISA_VALUE   32'h4000_1129   // RV32 IMAFD
`define MIMPID_VALUE 32'h0000_0001

`endif

/* verilog/csr_pkg.sv */
// Vector types shared by the CSR RTL and its testbench
// Import with a wildcard in the module header

`include "csr_consts.svh"

package csr_pkg;

  typedef logic [`XLEN-1:0] xlen_t;     // Data word, register value or PC
  typedef logic [11:0]      csr_addr_t; // CSR address
  typedef logic [2:0]       csr_op_t;   // funct3 of the CSR instruction

  // 00 U, 01 S, 11 M
  typedef logic [1:0]       priv_t;

  typedef logic [4:0]       cause_t;    // Exception cause code

  // NV DZ OF UF NX, MSB first
  typedef logic [4:0]       fflags_t;
  typedef logic [2:0]       frm_t;      // Rounding mode

  // Index of the implemented CSR, SEL_ codes
  typedef logic [4:0]       csr_sel_t;

endpackage

/* verilog/csr_decode.sv */
// CSR address decoder
// Maps the address to a register select and checks existence, privilege
// and read-only rules; a write is enabled only for a legal access

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_decode import csr_pkg::*; (
  input  csr_addr_t csr_addr,
  input  logic      csr_access,    // CSR instruction active
  input  logic      csr_we,        // Instruction writes the CSR
  input  priv_t     current_priv,
  output csr_sel_t  csr_sel,
  output logic      illegal_csr,
  output logic      write_ok       // Write enable after the checks
);

  logic csr_exists;
  logic priv_ok;
  logic read_only;
  logic access_legal;

  // ==============================
  // Address to select code
  always_comb begin
    case (csr_addr)
      `CSR_MSTATUS:   csr_sel = `SEL_MSTATUS;
      `CSR_MISA:      csr_sel = `SEL_MISA;
      `CSR_MTVEC:     csr_sel = `SEL_MTVEC;
      `CSR_MSCRATCH:  csr_sel = `SEL_MSCRATCH;
      `CSR_MEPC:      csr_sel = `SEL_MEPC;
      `CSR_MCAUSE:    csr_sel = `SEL_MCAUSE;
      `CSR_MTVAL:     csr_sel = `SEL_MTVAL;
      `CSR_MVENDORID: csr_sel = `SEL_MVENDORID;
      `CSR_MARCHID:   csr_sel = `SEL_MARCHID;
      `CSR_MIMPID:    csr_sel = `SEL_MIMPID;
      `CSR_MHARTID:   csr_sel = `SEL_MHARTID;
      `CSR_FFLAGS:    csr_sel = `SEL_FFLAGS;
      `CSR_FRM:       csr_sel = `SEL_FRM;
      `CSR_FCSR:      csr_sel = `SEL_FCSR;
      default:        csr_sel = `SEL_NONE;    // Unimplemented address
    endcase
  end

  // ==============================
  // Legality
  assign csr_exists = (csr_sel != `SEL_NONE);

  // Address bits 9:8 hold the lowest privilege allowed
  assign priv_ok = (current_priv >= csr_addr[9:8]);

  // Top bits 11 mark read-only space; misa is hardwired here too
  assign read_only = (csr_addr[11:10] == 2'b11) ||
                     (csr_sel == `SEL_MISA)     ||
                     (csr_sel == `SEL_MVENDORID) ||
                     (csr_sel == `SEL_MARCHID)  ||
                     (csr_sel == `SEL_MIMPID)   ||
                     (csr_sel == `SEL_MHARTID);

  // Read-only only matters when writing
  assign access_legal = csr_exists && priv_ok && !(csr_we && read_only);

  assign illegal_csr = csr_access && !access_legal;
  assign write_ok    = csr_we && access_legal;   // Illegal access never writes

endmodule

/* verilog/csr_read_modify.sv */
// CSR read mux and read-modify-write datapath
// Picks the addressed register value, then applies the write, set or
// clear operation of funct3 to form the value stored on a write

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_read_modify import csr_pkg::*; (
  input  csr_sel_t csr_sel,
  input  csr_op_t  csr_op,
  input  xlen_t    csr_wdata,     // rs1 value or zero-extended uimm
  input  xlen_t    mstatus_val,
  input  xlen_t    mtvec_val,
  input  xlen_t    mscratch_val,
  input  xlen_t    mepc_val,
  input  xlen_t    mcause_val,
  input  xlen_t    mtval_val,
  input  fflags_t  fflags_val,    // Already includes same-cycle FPU flags
  input  frm_t     frm_val,
  output xlen_t    csr_rdata,
  output xlen_t    write_value
);

  // ==============================
  // Read mux
  always_comb begin
    case (csr_sel)
      `SEL_MSTATUS:   csr_rdata = mstatus_val;
      `SEL_MISA:      csr_rdata = `MISA_VALUE;
      `SEL_MTVEC:     csr_rdata = mtvec_val;
      `SEL_MSCRATCH:  csr_rdata = mscratch_val;
      `SEL_MEPC:      csr_rdata = mepc_val;
      `SEL_MCAUSE:    csr_rdata = mcause_val;
      `SEL_MTVAL:     csr_rdata = mtval_val;
      `SEL_MVENDORID: csr_rdata = '0;   // Non-commercial
      `SEL_MARCHID:   csr_rdata = '0;
      `SEL_MIMPID:    csr_rdata = `MIMPID_VALUE;
      `SEL_MHARTID:   csr_rdata = '0;   // Single hart
      `SEL_FFLAGS:    csr_rdata = {{(`XLEN-5){1'b0}}, fflags_val};
      `SEL_FRM:       csr_rdata = {{(`XLEN-3){1'b0}}, frm_val};
      `SEL_FCSR:      csr_rdata = {{(`XLEN-8){1'b0}}, frm_val, fflags_val};
      default:        csr_rdata = '0;
    endcase
  end

  // ==============================
  // Modify step
  // Register and immediate forms differ only in where csr_wdata comes from
  always_comb begin
    case (csr_op)
      `CSR_RW, `CSR_RWI: write_value = csr_wdata;
      `CSR_RS, `CSR_RSI: write_value = csr_rdata | csr_wdata;    // Set bits
      `CSR_RC, `CSR_RCI: write_value = csr_rdata & ~csr_wdata;   // Clear bits
      default:           write_value = csr_rdata;                // Leave unchanged
    endcase
  end

endmodule

/* verilog/csr_machine_regs.sv */
// Machine trap registers and mstatus
// Handles trap entry, MRET and CSR writes; priority is trap entry,
// then MRET, then a CSR write in the same cycle

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_machine_regs import csr_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  csr_sel_t csr_sel,
  input  logic     write_ok,
  input  xlen_t    write_value,
  input  priv_t    current_priv,   // Saved into MPP on a trap
  input  logic     trap_entry,     // One-cycle pulse
  input  xlen_t    trap_pc,
  input  cause_t   trap_cause,
  input  xlen_t    trap_val,
  input  logic     mret,
  output xlen_t    mstatus_val,
  output xlen_t    mtvec_val,
  output xlen_t    mscratch_val,
  output xlen_t    mepc_val,
  output xlen_t    mcause_val,
  output xlen_t    mtval_val
);

  // mstatus kept as its three live fields
  logic  mie_q;
  logic  mpie_q;
  priv_t mpp_q;

  xlen_t mtvec_q;
  xlen_t mscratch_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  xlen_t mtval_q;

  // ==============================
  // Register update
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mie_q      <= 1'b0;
      mpie_q     <= 1'b0;
      mpp_q      <= `PRIV_M;     // Come out of reset in M
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else if (trap_entry) begin
      // Every trap lands in M
      mepc_q   <= {trap_pc[`XLEN-1:1], 1'b0};
      mcause_q <= {{(`XLEN-5){1'b0}}, trap_cause};
      mtval_q  <= trap_val;
      mpie_q   <= mie_q;         // Stack the enable
      mie_q    <= 1'b0;
      mpp_q    <= current_priv;
    end else if (mret) begin
      mie_q  <= mpie_q;          // Pop the enable
      mpie_q <= 1'b1;
      mpp_q  <= `PRIV_U;         // U is implemented
    end else if (write_ok) begin
      case (csr_sel)
        `SEL_MSTATUS: begin
          mie_q  <= write_value[`MSTATUS_MIE_BIT];
          mpie_q <= write_value[`MSTATUS_MPIE_BIT];
          mpp_q  <= write_value[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB];
        end
        `SEL_MTVEC:    mtvec_q    <= {write_value[`XLEN-1:2], 2'b00}; // 4-byte aligned
        `SEL_MSCRATCH: mscratch_q <= write_value;
        `SEL_MEPC:     mepc_q     <= {write_value[`XLEN-1:1], 1'b0};  // 2-byte aligned
        `SEL_MCAUSE:   mcause_q   <= write_value;
        `SEL_MTVAL:    mtval_q    <= write_value;
        default: begin
          // FP and read-only selects are not held here
        end
      endcase
    end
  end

  // ==============================
  // Rebuild mstatus, all other bits read zero
  always_comb begin
    mstatus_val = '0;
    mstatus_val[`MSTATUS_MIE_BIT]  = mie_q;
    mstatus_val[`MSTATUS_MPIE_BIT] = mpie_q;
    mstatus_val[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB] = mpp_q;
  end

  assign mtvec_val    = mtvec_q;      // Direct mode only
  assign mscratch_val = mscratch_q;
  assign mepc_val     = mepc_q;
  assign mcause_val   = mcause_q;
  assign mtval_val    = mtval_q;

endmodule

/* verilog/csr_fp_regs.sv */
// Floating-point CSRs fflags and frm
// Flags are sticky and accumulate by OR from the FPU; a CSR write to
// fflags or fcsr replaces the accumulation in that cycle

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_fp_regs import csr_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  csr_sel_t csr_sel,
  input  logic     write_ok,
  input  xlen_t    write_value,
  input  logic     fflags_we,     // FPU retiring with flags
  input  fflags_t  fflags_in,
  output fflags_t  fflags_val,    // Stored flags plus same-cycle FPU flags
  output frm_t     frm_val,
  output fflags_t  fflags_out     // Stored flags only
);

  fflags_t fflags_q;
  frm_t    frm_q;
  logic    flags_write;

  assign flags_write = write_ok && ((csr_sel == `SEL_FFLAGS) || (csr_sel == `SEL_FCSR));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fflags_q <= '0;
      frm_q    <= '0;            // RNE
    end else begin
      if (flags_write) begin
        fflags_q <= write_value[4:0];
      end else if (fflags_we) begin
        fflags_q <= fflags_q | fflags_in;   // Sticky
      end
      if (write_ok && (csr_sel == `SEL_FRM)) begin
        frm_q <= write_value[2:0];
      end else if (write_ok && (csr_sel == `SEL_FCSR)) begin
        frm_q <= write_value[7:5];          // fcsr bits 7:5
      end
    end
  end

  // Forward so a same-cycle read or set/clear sees the new flags
  assign fflags_val = fflags_we ? (fflags_q | fflags_in) : fflags_q;
  assign frm_val    = frm_q;
  assign fflags_out = fflags_q;

endmodule

/* verilog/csr_top.sv */
// Machine-mode CSR file of the RV32 core
// Reads and the illegal flag are combinational; writes, trap entry and
// MRET take effect on the next rising edge

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_top import csr_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  // CSR instruction
  input  logic      csr_access,
  input  logic      csr_we,
  input  csr_addr_t csr_addr,
  input  csr_op_t   csr_op,
  input  xlen_t     csr_wdata,
  input  priv_t     current_priv,
  output xlen_t     csr_rdata,
  output logic      illegal_csr,
  // Traps
  input  logic      trap_entry,
  input  xlen_t     trap_pc,
  input  cause_t    trap_cause,
  input  xlen_t     trap_val,
  input  logic      mret,
  output xlen_t     trap_vector,
  output xlen_t     mepc_out,
  output priv_t     mpp_out,
  output logic      mstatus_mie,
  // FPU side
  input  logic      fflags_we,
  input  fflags_t   fflags_in,
  output frm_t      frm_out,
  output fflags_t   fflags_out
);

  csr_sel_t csr_sel;
  logic     write_ok;
  xlen_t    write_value;

  xlen_t    mstatus_val;
  xlen_t    mtvec_val;
  xlen_t    mscratch_val;
  xlen_t    mepc_val;
  xlen_t    mcause_val;
  xlen_t    mtval_val;
  fflags_t  fflags_val;
  frm_t     frm_val;

  // ==============================
  // Datapath
  csr_decode csr_decode_i (
    .csr_addr     (csr_addr),
    .csr_access   (csr_access),
    .csr_we       (csr_we),
    .current_priv (current_priv),
    .csr_sel      (csr_sel),
    .illegal_csr  (illegal_csr),
    .write_ok     (write_ok)
  );

  csr_read_modify csr_read_modify_i (
    .csr_sel      (csr_sel),
    .csr_op       (csr_op),
    .csr_wdata    (csr_wdata),
    .mstatus_val  (mstatus_val),
    .mtvec_val    (mtvec_val),
    .mscratch_val (mscratch_val),
    .mepc_val     (mepc_val),
    .mcause_val   (mcause_val),
    .mtval_val    (mtval_val),
    .fflags_val   (fflags_val),
    .frm_val      (frm_val),
    .csr_rdata    (csr_rdata),
    .write_value  (write_value)
  );

  csr_machine_regs csr_machine_regs_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .csr_sel      (csr_sel),
    .write_ok     (write_ok),
    .write_value  (write_value),
    .current_priv (current_priv),
    .trap_entry   (trap_entry),
    .trap_pc      (trap_pc),
    .trap_cause   (trap_cause),
    .trap_val     (trap_val),
    .mret         (mret),
    .mstatus_val  (mstatus_val),
    .mtvec_val    (mtvec_val),
    .mscratch_val (mscratch_val),
    .mepc_val     (mepc_val),
    .mcause_val   (mcause_val),
    .mtval_val    (mtval_val)
  );

  csr_fp_regs csr_fp_regs_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .csr_sel     (csr_sel),
    .write_ok    (write_ok),
    .write_value (write_value),
    .fflags_we   (fflags_we),
    .fflags_in   (fflags_in),
    .fflags_val  (fflags_val),
    .frm_val     (frm_val),
    .fflags_out  (fflags_out)
  );

  // Status taps for the pipeline
  assign trap_vector = mtvec_val;   // No delegation, all traps to mtvec
  assign mepc_out    = mepc_val;
  assign mpp_out     = mstatus_val[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB];
  assign mstatus_mie = mstatus_val[`MSTATUS_MIE_BIT];
  assign frm_out     = frm_val;

endmodule

/* sim/csr_props.sv */
// Concurrent checks on the CSR file top level
// Bound into csr_top, reports only through failing assertions

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_props import csr_pkg::*; (
  input logic     clk,
  input logic     reset_n,
  input logic     csr_access,
  input logic     illegal_csr,
  input logic     trap_entry,
  input priv_t    current_priv,
  input logic     mstatus_mie,
  input priv_t    mpp_out,
  input xlen_t    mepc_out,
  input fflags_t  fflags_out,
  input logic     write_ok,      // Internal, legal write this cycle
  input csr_sel_t csr_sel        // Internal, decoded register
);

  logic flags_write;

  assign flags_write = write_ok && ((csr_sel == `SEL_FFLAGS) || (csr_sel == `SEL_FCSR));

  // ==============================
  illegal_needs_access: assert property (@(posedge clk) disable iff (!reset_n)
    !csr_access |-> !illegal_csr)
    else $error("illegal_csr high without csr_access");

  // Trap disables interrupts and stacks the privilege
  trap_stacks_state: assert property (@(posedge clk) disable iff (!reset_n)
    trap_entry |=> (!mstatus_mie && (mpp_out == $past(current_priv))))
    else $error("trap entry did not clear MIE or save the privilege into MPP");

  mepc_aligned: assert property (@(posedge clk) disable iff (!reset_n)
    mepc_out[0] == 1'b0)
    else $error("mepc_out bit 0 is set");

  // Set flags only drop on an FFLAGS or FCSR write
  flags_sticky: assert property (@(posedge clk) disable iff (!reset_n)
    !flags_write |=> ((fflags_out & $past(fflags_out)) == $past(fflags_out)))
    else $error("fflags_out lost a set bit without a flags write");

endmodule

bind csr_top csr_props csr_props_i (
  .clk          (clk),
  .reset_n      (reset_n),
  .csr_access   (csr_access),
  .illegal_csr  (illegal_csr),
  .trap_entry   (trap_entry),
  .current_priv (current_priv),
  .mstatus_mie  (mstatus_mie),
  .mpp_out      (mpp_out),
  .mepc_out     (mepc_out),
  .fflags_out   (fflags_out),
  .write_ok     (write_ok),
  .csr_sel      (csr_sel)
);

/* sim/csr_tb.sv */
// Trace-driven testbench for the machine-mode CSR file
// Reads one stimulus and expected-value line per cycle from sim/csr_trace.txt,
// drives it on the rising edge and checks the outputs on the falling edge

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_tb import csr_pkg::*; ();

  localparam int RESET_CYCLES     = 5;
  localparam int RESET_WAIT_LIMIT = 20;    // Cycles allowed for reset release
  localparam int TRACE_LIMIT      = 100;   // Cycles allowed for the whole trace
  localparam int TRACE_FIELDS     = 18;    // 13 inputs, 5 expected outputs

  logic      clk;
  logic      reset_n;
  logic      csr_access;
  logic      csr_we;
  csr_addr_t csr_addr;
  csr_op_t   csr_op;
  xlen_t     csr_wdata;
  priv_t     current_priv;
  xlen_t     csr_rdata;
  logic      illegal_csr;
  logic      trap_entry;
  xlen_t     trap_pc;
  cause_t    trap_cause;
  xlen_t     trap_val;
  logic      mret;
  xlen_t     trap_vector;
  xlen_t     mepc_out;
  priv_t     mpp_out;
  logic      mstatus_mie;
  logic      fflags_we;
  fflags_t   fflags_in;
  frm_t      frm_out;
  fflags_t   fflags_out;

  // Expected values of the line in flight
  xlen_t     exp_rdata;
  logic      exp_illegal;
  xlen_t     exp_mepc;
  logic      exp_mie;
  fflags_t   exp_fflags;
  logic      exp_access;   // Line reads a CSR
  csr_addr_t exp_addr;

  string     trace_lines[$];
  int        err_count  = 0;   // Wrong values
  int        fail_count = 0;   // Timeouts, file problems

  csr_top csr_top_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .csr_access   (csr_access),
    .csr_we       (csr_we),
    .csr_addr     (csr_addr),
    .csr_op       (csr_op),
    .csr_wdata    (csr_wdata),
    .current_priv (current_priv),
    .csr_rdata    (csr_rdata),
    .illegal_csr  (illegal_csr),
    .trap_entry   (trap_entry),
    .trap_pc      (trap_pc),
    .trap_cause   (trap_cause),
    .trap_val     (trap_val),
    .mret         (mret),
    .trap_vector  (trap_vector),
    .mepc_out     (mepc_out),
    .mpp_out      (mpp_out),
    .mstatus_mie  (mstatus_mie),
    .fflags_we    (fflags_we),
    .fflags_in    (fflags_in),
    .frm_out      (frm_out),
    .fflags_out   (fflags_out)
  );

  // ==============================
  // Clock and reset
  initial clk = 1'b0;
  always #2 clk = ~clk;   // 4 ns period

  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
  end

  // Trace lines without comments or blank lines
  task automatic load_trace();
    int    fd;
    int    code;
    string line;
    fd = $fopen("sim/csr_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file sim/csr_trace.txt");
      fail_count++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        trace_lines.push_back(line);
      end
    end
    $fclose(fd);
  endtask

  // Parse one line, drive its inputs, keep its expected values
  task automatic drive_line(input string line, input int line_no, output bit ok);
    int        n;
    logic      t_access, t_we, t_trap, t_mret, t_fwe, t_ill, t_mie;
    csr_addr_t t_addr;
    csr_op_t   t_op;
    priv_t     t_priv;
    cause_t    t_cause;
    fflags_t   t_fin, t_fflags;
    xlen_t     t_wdata, t_pc, t_val, t_rdata, t_mepc;
    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                t_access, t_we, t_addr, t_op, t_wdata, t_priv, t_trap, t_pc,
                t_cause, t_val, t_mret, t_fwe, t_fin,
                t_rdata, t_ill, t_mepc, t_mie, t_fflags);
    ok = (n == TRACE_FIELDS);
    if (!ok) begin
      $display("Trace line %0d is malformed, %0d fields read", line_no, n);
      fail_count++;
      return;
    end
    csr_access   <= t_access;
    csr_we       <= t_we;
    csr_addr     <= t_addr;
    csr_op       <= t_op;
    csr_wdata    <= t_wdata;
    current_priv <= t_priv;
    trap_entry   <= t_trap;
    trap_pc      <= t_pc;
    trap_cause   <= t_cause;
    trap_val     <= t_val;
    mret         <= t_mret;
    fflags_we    <= t_fwe;
    fflags_in    <= t_fin;
    exp_rdata    = t_rdata;
    exp_illegal  = t_ill;
    exp_mepc     = t_mepc;
    exp_mie      = t_mie;
    exp_fflags   = t_fflags;
    exp_access   = t_access;
    exp_addr     = t_addr;
  endtask

  // ==============================
  // Main sequence
  initial begin
    int waited;
    int cycle;
    bit ok;
    csr_access   = 1'b0;
    csr_we       = 1'b0;
    csr_addr     = '0;
    csr_op       = '0;
    csr_wdata    = '0;
    current_priv = `PRIV_M;
    trap_entry   = 1'b0;
    trap_pc      = '0;
    trap_cause   = '0;
    trap_val     = '0;
    mret         = 1'b0;
    fflags_we    = 1'b0;
    fflags_in    = '0;
    load_trace();
    if (trace_lines.size() == 0) begin
      $display("No stimulus lines were loaded from the trace");
      fail_count++;
    end
    waited = 0;
    while (reset_n !== 1'b1 && waited < RESET_WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (reset_n !== 1'b1) begin
      $display("Timeout: reset_n still low after %0d cycles", waited);
      fail_count++;
    end else begin
      cycle = 0;
      while (cycle < trace_lines.size() && cycle < TRACE_LIMIT) begin
        @(posedge clk);
        drive_line(trace_lines[cycle], cycle + 1, ok);
        @(negedge clk);            // Outputs settled, half a cycle after drive
        if (ok) begin
          if (csr_rdata !== exp_rdata) begin
            $display("ERR t=%0t line %0d csr_rdata got %h expected %h",
                     $time, cycle + 1, csr_rdata, exp_rdata);
            err_count++;
          end
          if (illegal_csr !== exp_illegal) begin
            $display("ERR t=%0t line %0d illegal_csr got %b expected %b",
                     $time, cycle + 1, illegal_csr, exp_illegal);
            err_count++;
          end
          if (mepc_out !== exp_mepc) begin
            $display("ERR t=%0t line %0d mepc_out got %h expected %h",
                     $time, cycle + 1, mepc_out, exp_mepc);
            err_count++;
          end
          if (mstatus_mie !== exp_mie) begin
            $display("ERR t=%0t line %0d mstatus_mie got %b expected %b",
                     $time, cycle + 1, mstatus_mie, exp_mie);
            err_count++;
          end
          if (fflags_out !== exp_fflags) begin
            $display("ERR t=%0t line %0d fflags_out got %h expected %h",
                     $time, cycle + 1, fflags_out, exp_fflags);
            err_count++;
          end
          // Status taps match the word the same line reads back
          if (exp_access && !exp_illegal) begin
            if (exp_addr == `CSR_MTVEC && trap_vector !== exp_rdata) begin
              $display("ERR t=%0t line %0d trap_vector got %h expected %h",
                       $time, cycle + 1, trap_vector, exp_rdata);
              err_count++;
            end
            if (exp_addr == `CSR_MSTATUS &&
                mpp_out !== exp_rdata[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB]) begin
              $display("ERR t=%0t line %0d mpp_out got %h expected %h",
                       $time, cycle + 1, mpp_out,
                       exp_rdata[`MSTATUS_MPP_MSB:`MSTATUS_MPP_LSB]);
              err_count++;
            end
            if (exp_addr == `CSR_FRM && frm_out !== exp_rdata[2:0]) begin
              $display("ERR t=%0t line %0d frm_out got %h expected %h",
                       $time, cycle + 1, frm_out, exp_rdata[2:0]);
              err_count++;
            end
            if (exp_addr == `CSR_FCSR && frm_out !== exp_rdata[7:5]) begin
              $display("ERR t=%0t line %0d frm_out got %h expected %h",
                       $time, cycle + 1, frm_out, exp_rdata[7:5]);
              err_count++;
            end
          end
        end
        cycle++;
      end
      if (cycle < trace_lines.size()) begin
        $display("Timeout: trace not finished within %0d cycles", TRACE_LIMIT);
        fail_count++;
      end
    end
    $display("Run done: %0d value errors, %0d other failures", err_count, fail_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* sim/csr_trace.txt */
# Inputs: acc we addr op wdata priv trap pc cause tval mret fwe fin (all hex)
# Expected: rdata illegal mepc mie fflags, registered outputs show state before this edge
0 0 000 0 00000000 3 0 00000000 00 00000000 0 0 00 00000000 0 00000000 0 00
1 1 340 1 12345678 3 0 00000000 00 00000000 0 0 00 00000000 0 00000000 0 00
1 1 340 2 0000FF00 3 0 00000000 00 00000000 0 0 00 12345678 0 00000000 0 00
1 1 340 3 12000000 3 0 00000000 00 00000000 0 0 00 1234FF78 0 00000000 0 00
1 1 340 6 00000005 3 0 00000000 00 00000000 0 0 00 0034FF78 0 00000000 0 00
1 1 340 7 00000018 3 0 00000000 00 00000000 0 0 00 0034FF7D 0 00000000 0 00
1 1 340 5 0000001F 3 0 00000000 00 00000000 0 0 00 0034FF65 0 00000000 0 00
1 0 340 2 00000000 3 0 00000000 00 00000000 0 0 00 0000001F 0 00000000 0 00
1 1 305 1 80000103 3 0 00000000 00 00000000 0 0 00 00000000 0 00000000 0 00
1 0 305 2 00000000 3 0 00000000 00 00000000 0 0 00 80000100 0 00000000 0 00
1 0 301 2 00000000 3 0 00000000 00 00000000 0 0 00 40001129 0 00000000 0 00
1 0 F13 2 00000000 3 0 00000000 00 00000000 0 0 00 00000001 0 00000000 0 00
1 0 F11 2 00000000 3 0 00000000 00 00000000 0 0 00 00000000 0 00000000 0 00
1 0 F12 2 00000000 3 0 00000000 00 00000000 0 0 00 00000000 0 00000000 0 00
1 0 F14 2 00000000 3 0 00000000 00 00000000 0 0 00 00000000 0 00000000 0 00
1 1 301 1 00000000 3 0 00000000 00 00000000 0 0 00 40001129 1 00000000 0 00
1 0 301 2 00000000 3 0 00000000 00 00000000 0 0 00 40001129 0 00000000 0 00
1 0 7C0 2 00000000 3 0 00000000 00 00000000 0 0 00 00000000 1 00000000 0 00
1 1 340 1 DEADBEEF 0 0 00000000 00 00000000 0 0 00 0000001F 1 00000000 0 00
1 0 340 2 00000000 3 0 00000000 00 00000000 0 0 00 0000001F 0 00000000 0 00
0 1 7C0 1 00000000 3 0 00000000 00 00000000 0 0 00 00000000 0 00000000 0 00
1 1 300 2 00000008 3 0 00000000 00 00000000 0 0 00 00001800 0 00000000 0 00
0 0 000 0 00000000 0 1 80000044 02 00C0FFEE 0 0 00 00000000 0 00000000 1 00
1 0 341 2 00000000 3 0 00000000 00 00000000 0 0 00 80000044 0 80000044 0 00
1 0 342 2 00000000 3 0 00000000 00 00000000 0 0 00 00000002 0 80000044 0 00
1 0 343 2 00000000 3 0 00000000 00 00000000 0 0 00 00C0FFEE 0 80000044 0 00
1 0 300 2 00000000 3 0 00000000 00 00000000 0 0 00 00000080 0 80000044 0 00
0 0 000 0 00000000 3 0 00000000 00 00000000 1 0 00 00000000 0 80000044 0 00
1 0 300 2 00000000 3 0 00000000 00 00000000 0 0 00 00000088 0 80000044 1 00
1 0 001 2 00000000 3 0 00000000 00 00000000 0 1 05 00000005 0 80000044 1 00
1 0 001 2 00000000 3 0 00000000 00 00000000 0 1 0A 0000000F 0 80000044 1 05
1 0 001 2 00000000 3 0 00000000 00 00000000 0 0 00 0000000F 0 80000044 1 0F
1 1 003 1 000000A3 3 0 00000000 00 00000000 0 1 10 0000001F 0 80000044 1 0F
1 0 003 2 00000000 3 0 00000000 00 00000000 0 0 00 000000A3 0 80000044 1 03
1 0 002 2 00000000 3 0 00000000 00 00000000 0 0 00 00000005 0 80000044 1 03
0 0 000 0 00000000 3 0 00000000 00 00000000 0 0 00 00000000 0 80000044 1 03

/* src.f */
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_decode.sv
verilog/csr_read_modify.sv
verilog/csr_machine_regs.sv
verilog/csr_fp_regs.sv
verilog/csr_top.sv
sim/csr_props.sv
sim/csr_tb.sv
